// ==== src/bridge_pkg.sv ====
/*
 * bridge definitions
 * host bridge address map, settings field widths and
 * controller key bitmap positions for the nes shell glue
 */
`default_nettype none

package bridge_pkg;

  typedef logic [31:0] bridge_addr_t;
  typedef logic [31:0] bridge_data_t;
  typedef logic [1:0]  edge_mask_t;
  typedef logic [2:0]  palette_t;
  typedef logic [9:0]  datatable_addr_t;
  typedef logic [15:0] key_map_t;
  // bit 0 a, then b, select, start, up, down, left, bit 7 right
  typedef logic [7:0]  nes_buttons_t;

  // settings registers written by the host
  localparam bridge_addr_t addr_hide_overscan  = 32'h0000_0200;
  localparam bridge_addr_t addr_mask_edges     = 32'h0000_0204;
  localparam bridge_addr_t addr_extra_sprites  = 32'h0000_0208;
  localparam bridge_addr_t addr_palette        = 32'h0000_020C;
  localparam bridge_addr_t addr_multitap       = 32'h0000_0300;

  // read regions by top nibble / top byte
  localparam logic [3:0] region_save_data  = 4'h2;
  localparam logic [3:0] region_save_state = 4'h4;
  localparam logic [7:0] cmd_region_byte   = 8'hF8;

  // data slot table entry for save ram
  localparam bridge_data_t    save_ram_size   = 32'h0004_0000;
  // slot index 1 maps to table word 3
  localparam datatable_addr_t save_slot_entry = 10'd3;

  // key bitmap positions
  localparam int key_up     = 0;
  localparam int key_down   = 1;
  localparam int key_left   = 2;
  localparam int key_right  = 3;
  localparam int key_a      = 4;
  localparam int key_b      = 5;
  localparam int key_select = 14;
  localparam int key_start  = 15;

endpackage

`default_nettype wire

// ==== src/video_pkg.sv ====
/*
 * video definitions
 * pixel width, hsync delay and the blanking slot word layout
 */
`default_nettype none

package video_pkg;

  // 8 bits per channel, red on top
  typedef logic [23:0] rgb_t;

  // hsync delay counter
  typedef logic [2:0] hs_count_t;

  // hsync lands this many cycles after the core edge
  // keeps it clear of the vsync pulse
  localparam hs_count_t hs_delay_cycles = 3'd7;

  // slot word sent in the first blank cycle after active video
  // only the overscan flag is carried for now
  localparam int slot_overscan_bit = 13;

endpackage

`default_nettype wire

// ==== src/bridge_decode.sv ====
/*
 * bridge decode
 * host writes into the five settings registers and
 * the read data mux across the bridge regions
 */
`default_nettype none

module bridge_decode (
  input  wire                           clk_74a,
  input  wire                           pll_core_locked,
  input  wire bridge_pkg::bridge_addr_t bridge_addr,
  input  wire                           bridge_wr,
  input  wire bridge_pkg::bridge_data_t bridge_wr_data,
  input  wire bridge_pkg::bridge_data_t cmd_rd_data,
  input  wire bridge_pkg::bridge_data_t save_data_rd_data,
  input  wire bridge_pkg::bridge_data_t save_state_rd_data,
  output bridge_pkg::bridge_data_t      bridge_rd_data,
  output logic                          hide_overscan,
  output logic                          allow_extra_sprites,
  output logic                          multitap_enabled,
  output bridge_pkg::edge_mask_t        mask_vid_edges,
  output bridge_pkg::palette_t          selected_palette
);

  //////////////////////////////////////////////////////////////////////
  // settings registers

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hide_overscan       <= 1'b0;
      mask_vid_edges      <= '0;
      allow_extra_sprites <= 1'b0;
      selected_palette    <= '0;
      multitap_enabled    <= 1'b0;
    end else if (bridge_wr) begin
      // exact address match only
      case (bridge_addr)
        bridge_pkg::addr_hide_overscan: begin
          hide_overscan <= bridge_wr_data[0];
        end
        bridge_pkg::addr_mask_edges: begin
          mask_vid_edges <= bridge_wr_data[1:0];
        end
        bridge_pkg::addr_extra_sprites: begin
          allow_extra_sprites <= bridge_wr_data[0];
        end
        bridge_pkg::addr_palette: begin
          selected_palette <= bridge_wr_data[2:0];
        end
        bridge_pkg::addr_multitap: begin
          multitap_enabled <= bridge_wr_data[0];
        end
        default: begin
          // other addresses belong to other devices
        end
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read data mux

  // save regions win over the command region
  always_comb begin
    if (bridge_addr[31:28] == bridge_pkg::region_save_data) begin
      bridge_rd_data = save_data_rd_data;
    end else if (bridge_addr[31:28] == bridge_pkg::region_save_state) begin
      bridge_rd_data = save_state_rd_data;
    end else if (bridge_addr[31:24] == bridge_pkg::cmd_region_byte) begin
      bridge_rd_data = cmd_rd_data;
    end else begin
      // unmapped reads return zero
      bridge_rd_data = '0;
    end
  end

endmodule

`default_nettype wire

// ==== src/dataslot_status.sv ====
/*
 * data slot status
 * keeps the save ram size entry of the slot table written
 * and holds the download flag across a slot write
 */
`default_nettype none

module dataslot_status (
  input  wire                            clk_74a,
  input  wire                            pll_core_locked,
  input  wire                            has_save,
  input  wire                            dataslot_requestwrite,
  input  wire                            dataslot_allcomplete,
  output logic                           datatable_wren,
  output bridge_pkg::datatable_addr_t    datatable_addr,
  output bridge_pkg::bridge_data_t       datatable_data,
  output logic                           ioctl_download
);

  // table entry rewritten every cycle
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      datatable_wren <= 1'b0;
      datatable_addr <= '0;
      datatable_data <= '0;
    end else begin
      datatable_wren <= 1'b1;
      datatable_addr <= bridge_pkg::save_slot_entry;
      // size is zero when the cart has no battery ram
      datatable_data <= has_save ? bridge_pkg::save_ram_size : '0;
    end
  end

  // download flag
  // request takes priority over completion
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      ioctl_download <= 1'b0;
    end else if (dataslot_requestwrite) begin
      ioctl_download <= 1'b1;
    end else if (dataslot_allcomplete) begin
      ioctl_download <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== src/video_output_conditioner.sv ====
/*
 * video output conditioner
 * registers core video for the scaler, inserts the slot word
 * after each active span, delays hsync and pulses vsync
 */
`default_nettype none

module video_output_conditioner (
  input  wire                   clk_74a,
  input  wire                   pll_core_locked,
  input  wire                   h_blank,
  input  wire                   v_blank,
  input  wire                   core_hs,
  input  wire                   core_vs,
  input  wire                   hide_overscan,
  input  wire video_pkg::rgb_t  core_rgb,
  output logic                  video_de,
  output logic                  video_hs,
  output logic                  video_vs,
  output video_pkg::rgb_t       video_rgb
);

  logic                 de;
  logic                 de_prev;
  logic                 hs_prev;
  logic                 vs_prev;
  video_pkg::hs_count_t hs_delay;
  video_pkg::rgb_t      slot_word;

  // active when neither blank is set
  assign de = ~(h_blank | v_blank);

  // slot word
  always_comb begin
    slot_word = '0;
    slot_word[video_pkg::slot_overscan_bit] = hide_overscan;
  end

  //////////////////////////////////////////////////////////////////////
  // enable and pixel data

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      video_de  <= 1'b0;
      video_rgb <= '0;
      de_prev   <= 1'b0;
    end else begin
      video_de <= de;
      de_prev  <= de;
      if (de) begin
        video_rgb <= core_rgb;
      end else if (de_prev) begin
        // first blank cycle after active video
        video_rgb <= slot_word;
      end else begin
        video_rgb <= '0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // sync shaping

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      video_hs <= 1'b0;
      video_vs <= 1'b0;
      hs_prev  <= 1'b0;
      vs_prev  <= 1'b0;
      hs_delay <= '0;
    end else begin
      hs_prev <= core_hs;
      vs_prev <= core_vs;

      // single cycle on the core vsync rising edge
      video_vs <= core_vs & ~vs_prev;

      // fire as the count passes one
      video_hs <= (hs_delay == video_pkg::hs_count_t'(1));

      // a new hsync edge restarts the delay
      if (core_hs && !hs_prev) begin
        hs_delay <= video_pkg::hs_delay_cycles;
      end else if (hs_delay != '0) begin
        hs_delay <= hs_delay - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/player_buttons.sv ====
/*
 * player buttons
 * picks the eight nes buttons out of each controller key bitmap
 */
`default_nettype none

module player_buttons (
  input  wire                          clk_74a,
  input  wire                          pll_core_locked,
  input  wire bridge_pkg::key_map_t    cont1_key,
  input  wire bridge_pkg::key_map_t    cont2_key,
  input  wire bridge_pkg::key_map_t    cont3_key,
  input  wire bridge_pkg::key_map_t    cont4_key,
  output bridge_pkg::nes_buttons_t     p1_buttons,
  output bridge_pkg::nes_buttons_t     p2_buttons,
  output bridge_pkg::nes_buttons_t     p3_buttons,
  output bridge_pkg::nes_buttons_t     p4_buttons
);

  // bitmap to console order, a in bit 0
  function automatic bridge_pkg::nes_buttons_t map_keys(input bridge_pkg::key_map_t key);
    map_keys = {key[bridge_pkg::key_right], key[bridge_pkg::key_left],
                key[bridge_pkg::key_down],  key[bridge_pkg::key_up],
                key[bridge_pkg::key_start], key[bridge_pkg::key_select],
                key[bridge_pkg::key_b],     key[bridge_pkg::key_a]};
  endfunction

  // one register stage per player
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      p1_buttons <= '0;
      p2_buttons <= '0;
      p3_buttons <= '0;
      p4_buttons <= '0;
    end else begin
      p1_buttons <= map_keys(cont1_key);
      p2_buttons <= map_keys(cont2_key);
      p3_buttons <= map_keys(cont3_key);
      p4_buttons <= map_keys(cont4_key);
    end
  end

endmodule

`default_nettype wire

// ==== src/nes_core_shell.sv ====
/*
 * nes core shell
 * bridge facing glue of the nes core, all on clk_74a
 */
`default_nettype none

module nes_core_shell (
  input  wire                           clk_74a,
  input  wire                           pll_core_locked,
  // bridge bus
  input  wire bridge_pkg::bridge_addr_t bridge_addr,
  input  wire                           bridge_wr,
  input  wire bridge_pkg::bridge_data_t bridge_wr_data,
  input  wire bridge_pkg::bridge_data_t cmd_rd_data,
  input  wire bridge_pkg::bridge_data_t save_data_rd_data,
  input  wire bridge_pkg::bridge_data_t save_state_rd_data,
  output wire bridge_pkg::bridge_data_t bridge_rd_data,
  // settings
  output wire                           hide_overscan,
  output wire                           allow_extra_sprites,
  output wire                           multitap_enabled,
  output wire bridge_pkg::edge_mask_t   mask_vid_edges,
  output wire bridge_pkg::palette_t     selected_palette,
  // data slots
  input  wire                           has_save,
  input  wire                           dataslot_requestwrite,
  input  wire                           dataslot_allcomplete,
  output wire                           datatable_wren,
  output wire bridge_pkg::datatable_addr_t datatable_addr,
  output wire bridge_pkg::bridge_data_t datatable_data,
  output wire                           ioctl_download,
  // video
  input  wire                           h_blank,
  input  wire                           v_blank,
  input  wire                           core_hs,
  input  wire                           core_vs,
  input  wire video_pkg::rgb_t          core_rgb,
  output wire                           video_de,
  output wire                           video_hs,
  output wire                           video_vs,
  output wire video_pkg::rgb_t          video_rgb,
  // controllers
  input  wire bridge_pkg::key_map_t     cont1_key,
  input  wire bridge_pkg::key_map_t     cont2_key,
  input  wire bridge_pkg::key_map_t     cont3_key,
  input  wire bridge_pkg::key_map_t     cont4_key,
  output wire bridge_pkg::nes_buttons_t p1_buttons,
  output wire bridge_pkg::nes_buttons_t p2_buttons,
  output wire bridge_pkg::nes_buttons_t p3_buttons,
  output wire bridge_pkg::nes_buttons_t p4_buttons
);

  bridge_decode u_bridge_decode (.*);

  dataslot_status u_dataslot_status (.*);

  // overscan setting feeds the slot word
  video_output_conditioner u_video_output_conditioner (.*);

  player_buttons u_player_buttons (.*);

endmodule

`default_nettype wire

// ==== bench/nes_core_shell_chk.sv ====
/*
 * nes core shell checker
 * bound assertions on sync pulse width and slot table writes
 */
`default_nettype none

module nes_core_shell_chk (
  input wire                              clk_74a,
  input wire                              pll_core_locked,
  input wire                              video_hs,
  input wire                              video_vs,
  input wire                              datatable_wren,
  input wire bridge_pkg::datatable_addr_t datatable_addr
);
  timeunit 1ns;
  timeprecision 100ps;

  // sync outputs are single cycle pulses
  vs_single: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    video_vs |=> !video_vs) else $error("video_vs high for two cycles");
  hs_single: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    video_hs |=> !video_hs) else $error("video_hs high for two cycles");

  // only the save size entry is ever written
  table_entry: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    datatable_wren |-> datatable_addr == bridge_pkg::save_slot_entry)
    else $error("table written at an unexpected address");

endmodule

bind nes_core_shell nes_core_shell_chk u_chk (.*);

`default_nettype wire

// ==== bench/nes_core_shell_tb.sv ====
/*
 * nes core shell testbench
 * random bridge, slot, video and key stimulus, checked every
 * cycle against a cycle model of the glue logic
 */
`default_nettype none

module nes_core_shell_tb;
  timeunit 1ns;
  timeprecision 100ps;

  logic                          clk_74a = 1'b0;
  logic                          pll_core_locked;
  bridge_pkg::bridge_addr_t      bridge_addr;
  bridge_pkg::bridge_data_t      bridge_wr_data, cmd_rd_data, save_data_rd_data;
  bridge_pkg::bridge_data_t      save_state_rd_data;
  logic                          bridge_wr, has_save, dataslot_requestwrite;
  logic                          dataslot_allcomplete, h_blank, v_blank, core_hs, core_vs;
  video_pkg::rgb_t               core_rgb;
  bridge_pkg::key_map_t          cont1_key, cont2_key, cont3_key, cont4_key;
  wire bridge_pkg::bridge_data_t bridge_rd_data, datatable_data;
  wire                           hide_overscan, allow_extra_sprites, multitap_enabled;
  wire bridge_pkg::edge_mask_t   mask_vid_edges;
  wire bridge_pkg::palette_t     selected_palette;
  wire                           datatable_wren, ioctl_download, video_de, video_hs, video_vs;
  wire bridge_pkg::datatable_addr_t datatable_addr;
  wire video_pkg::rgb_t          video_rgb;
  wire bridge_pkg::nes_buttons_t p1_buttons, p2_buttons, p3_buttons, p4_buttons;

  // model state
  // exp_set packs multitap, palette, extra sprites, edge mask, overscan
  logic [15:0]                   lfsr = 16'd46;
  logic [7:0]                    exp_set;
  bridge_pkg::bridge_data_t      exp_table;
  logic                          exp_wren, exp_dl, exp_de, exp_hs, exp_vs, hs_q, vs_q;
  video_pkg::rgb_t               exp_rgb;
  bridge_pkg::nes_buttons_t      exp_btn [4];
  int                            hs_age;
  int                            hs_pulses = 0;

  nes_core_shell UUT (.*);

  always #4 clk_74a = ~clk_74a;

  //////////////////////////////////////////////////////////////////////
  // random source and reference functions

  // taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    rand_bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      rand_bits = {rand_bits[30:0], lfsr[0]};
    end
  endfunction

  function automatic logic [7:0] next_settings(input logic [7:0] cur, input logic wr,
      input bridge_pkg::bridge_addr_t a, input bridge_pkg::bridge_data_t d);
    next_settings = cur;
    if (wr) begin
      case (a)
        32'h200: next_settings[0] = d[0];
        32'h204: next_settings[2:1] = d[1:0];
        32'h208: next_settings[3] = d[0];
        32'h20C: next_settings[6:4] = d[2:0];
        32'h300: next_settings[7] = d[0];
        default: next_settings = cur;
      endcase
    end
  endfunction

  // save regions first, then the command byte
  function automatic bridge_pkg::bridge_data_t expected_read(input bridge_pkg::bridge_addr_t a);
    if (a[31:28] == 4'h2) return save_data_rd_data;
    if (a[31:28] == 4'h4) return save_state_rd_data;
    if (a[31:24] == 8'hF8) return cmd_rd_data;
    return '0;
  endfunction

  function automatic bridge_pkg::bridge_data_t expected_table(input logic save);
    return save ? 32'h0004_0000 : 32'h0;
  endfunction

  function automatic bridge_pkg::nes_buttons_t expected_buttons(input bridge_pkg::key_map_t k);
    int pos [8];
    pos = '{bridge_pkg::key_a, bridge_pkg::key_b, bridge_pkg::key_select,
            bridge_pkg::key_start, bridge_pkg::key_up, bridge_pkg::key_down,
            bridge_pkg::key_left, bridge_pkg::key_right};
    for (int i = 0; i < 8; i++) begin
      expected_buttons[i] = k[pos[i]];
    end
  endfunction

  //////////////////////////////////////////////////////////////////////
  // compare tasks

  task automatic fail_with(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) fail_with($sformatf("FAILED %s expected %b actual %b", name, exp, act));
  endtask

  task automatic check_data(input string name, input bridge_pkg::bridge_data_t exp,
      input bridge_pkg::bridge_data_t act);
    if (act !== exp) fail_with($sformatf("FAILED %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_table_addr(input string name, input bridge_pkg::datatable_addr_t exp,
      input bridge_pkg::datatable_addr_t act);
    if (act !== exp) fail_with($sformatf("FAILED %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_rgb(input string name, input video_pkg::rgb_t exp,
      input video_pkg::rgb_t act);
    if (act !== exp) fail_with($sformatf("FAILED %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_buttons(input string name, input bridge_pkg::nes_buttons_t exp,
      input bridge_pkg::nes_buttons_t act);
    if (act !== exp) fail_with($sformatf("FAILED %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_palette(input string name, input bridge_pkg::palette_t exp,
      input bridge_pkg::palette_t act);
    if (act !== exp) fail_with($sformatf("FAILED %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_mask(input string name, input bridge_pkg::edge_mask_t exp,
      input bridge_pkg::edge_mask_t act);
    if (act !== exp) fail_with($sformatf("FAILED %s expected %h actual %h", name, exp, act));
  endtask

  //////////////////////////////////////////////////////////////////////
  // cycle model
  // inputs are stable at the rising edge

  always @(posedge clk_74a) begin
    if (!pll_core_locked) begin
      exp_set   = '0;
      exp_wren  = 1'b0;
      exp_table = '0;
      exp_dl    = 1'b0;
      exp_btn   = '{default: '0};
      exp_de    = 1'b0;
      exp_rgb   = '0;
      exp_hs    = 1'b0;
      exp_vs    = 1'b0;
      hs_q      = 1'b0;
      vs_q      = 1'b0;
      hs_age    = 8;
    end else begin
      // slot word after the last active cycle
      // overscan flag at bit 13
      if (!(h_blank || v_blank)) begin
        exp_rgb = core_rgb;
      end else begin
        exp_rgb = '0;
        exp_rgb[13] = exp_de & exp_set[0];
      end
      exp_de = !(h_blank || v_blank);
      exp_vs = core_vs && !vs_q;
      // pulse on the seventh edge after a rise, even if a new rise lands there
      exp_hs = (hs_age == 6);
      if (exp_hs) hs_pulses++;
      // cycles since the last hsync rise
      // idles at 8
      if (core_hs && !hs_q) begin
        hs_age = 0;
      end else if (hs_age < 8) begin
        hs_age++;
      end
      hs_q = core_hs;
      vs_q = core_vs;
      exp_set   = next_settings(exp_set, bridge_wr, bridge_addr, bridge_wr_data);
      exp_wren  = 1'b1;
      exp_table = expected_table(has_save);
      // request wins a tie
      if (dataslot_requestwrite) begin
        exp_dl = 1'b1;
      end else if (dataslot_allcomplete) begin
        exp_dl = 1'b0;
      end
      exp_btn[0] = expected_buttons(cont1_key);
      exp_btn[1] = expected_buttons(cont2_key);
      exp_btn[2] = expected_buttons(cont3_key);
      exp_btn[3] = expected_buttons(cont4_key);
    end
  end

  // outputs settle well before the falling edge
  always @(negedge clk_74a) begin
    check_data("read mux", expected_read(bridge_addr), bridge_rd_data);
    check_bit("hide_overscan", exp_set[0], hide_overscan);
    check_mask("mask_vid_edges", exp_set[2:1], mask_vid_edges);
    check_bit("allow_extra_sprites", exp_set[3], allow_extra_sprites);
    check_palette("selected_palette", exp_set[6:4], selected_palette);
    check_bit("multitap_enabled", exp_set[7], multitap_enabled);
    check_bit("datatable_wren", exp_wren, datatable_wren);
    check_table_addr("datatable_addr", exp_wren ? 10'd3 : 10'd0, datatable_addr);
    check_data("datatable_data", exp_table, datatable_data);
    check_bit("ioctl_download", exp_dl, ioctl_download);
    check_bit("video_de", exp_de, video_de);
    check_bit("video_hs", exp_hs, video_hs);
    check_bit("video_vs", exp_vs, video_vs);
    check_rgb("video_rgb", exp_rgb, video_rgb);
    check_buttons("p1_buttons", exp_btn[0], p1_buttons);
    check_buttons("p2_buttons", exp_btn[1], p2_buttons);
    check_buttons("p3_buttons", exp_btn[2], p3_buttons);
    check_buttons("p4_buttons", exp_btn[3], p4_buttons);
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus

  task automatic drive_random();
    logic [31:0] r;
    r = rand_bits(32);
    // settings addresses, each region, a near miss, then anything
    case (rand_bits(4))
      0: bridge_addr = 32'h200;
      1: bridge_addr = 32'h204;
      2: bridge_addr = 32'h208;
      3: bridge_addr = 32'h20C;
      4: bridge_addr = 32'h300;
      5: bridge_addr = {4'h2, r[27:0]};
      6: bridge_addr = {4'h4, r[27:0]};
      7: bridge_addr = {8'hF8, r[23:0]};
      8: bridge_addr = 32'h210;
      default: bridge_addr = r;
    endcase
    bridge_wr             = rand_bits(1) != 0;
    bridge_wr_data        = rand_bits(32);
    cmd_rd_data           = rand_bits(32);
    save_data_rd_data     = rand_bits(32);
    save_state_rd_data    = rand_bits(32);
    has_save              = rand_bits(1) != 0;
    dataslot_requestwrite = rand_bits(3) == 0;
    dataslot_allcomplete  = rand_bits(2) == 0;
    // mostly active video, sparse sync edges
    h_blank  = rand_bits(2) == 0;
    v_blank  = rand_bits(3) == 0;
    core_hs  = rand_bits(4) == 0;
    core_vs  = rand_bits(3) == 0;
    core_rgb = 24'(rand_bits(24));
    cont1_key = 16'(rand_bits(16));
    cont2_key = 16'(rand_bits(16));
    cont3_key = 16'(rand_bits(16));
    cont4_key = 16'(rand_bits(16));
  endtask

  initial begin
    int waited;
    pll_core_locked = 1'b0;
    bridge_addr = '0;
    bridge_wr = 1'b0;
    bridge_wr_data = '0;
    cmd_rd_data = '0;
    save_data_rd_data = '0;
    save_state_rd_data = '0;
    has_save = 1'b0;
    dataslot_requestwrite = 1'b0;
    dataslot_allcomplete = 1'b0;
    {h_blank, v_blank, core_hs, core_vs} = 4'b1100;
    core_rgb = '0;
    {cont1_key, cont2_key, cont3_key, cont4_key} = '0;
    repeat (8) @(posedge clk_74a);
    #1;
    pll_core_locked = 1'b1;
    // table writes start on the first edge after release
    waited = 0;
    while (datatable_wren !== 1'b1) begin
      @(posedge clk_74a);
      #1;
      waited++;
      if (waited > 4) fail_with("table write enable did not rise after reset release");
    end
    for (int cyc = 0; cyc < 800; cyc++) begin
      drive_random();
      @(posedge clk_74a);
      #1;
    end
    @(negedge clk_74a);
    if (hs_pulses == 0) begin
      fail_with("no delayed hsync pulse was produced during the run");
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== nes_shell.f ====
src/bridge_pkg.sv
src/video_pkg.sv
src/bridge_decode.sv
src/dataslot_status.sv
src/video_output_conditioner.sv
src/player_buttons.sv
src/nes_core_shell.sv
bench/nes_core_shell_chk.sv
bench/nes_core_shell_tb.sv
